//--- mem_pkg.sv
package mem_pkg;

    // one-hot memory operation bits
    localparam int mem_lb  = 0;
    localparam int mem_lh  = 1;
    localparam int mem_lw  = 2;
    localparam int mem_lbu = 3;
    localparam int mem_lhu = 4;
    localparam int mem_sb  = 5;
    localparam int mem_sh  = 6;
    localparam int mem_sw  = 7;

    localparam int mul_lo   = 0;
    localparam int mul_hi_s = 1;
    localparam int mul_hi_u = 2;

    localparam int div_q_s = 0;
    localparam int div_q_u = 1;
    localparam int div_r_s = 2;
    localparam int div_r_u = 3;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [31:0] rkd_value;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [7:0]  mem_op;
        logic [2:0]  mul_op;
        logic [3:0]  div_op;
        logic        res_from_mul;
        logic        res_from_div;
        logic        res_from_mem;
        logic        gr_we;
        logic        mem_we;
        logic [4:0]  dest;
        logic        has_exception;
        logic [5:0]  ecode;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] src1;
        logic [31:0] src2;
        logic [2:0]  mul_op;
        logic [3:0]  div_op;
        logic        is_div;
    } muldiv_req_t;

    typedef struct packed {
        logic [63:0] product;
        logic [31:0] quotient;
        logic [31:0] remainder;
    } muldiv_resp_t;

    // result holds the byte address for loads
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [7:0]  mem_op;
        logic        res_from_mem;
        logic        gr_we;
        logic [4:0]  dest;
        logic        has_exception;
        logic [5:0]  ecode;
    } mem_wb_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  dest;
        logic        we;
        logic [31:0] data;
        logic        exc;
        logic [5:0]  ecode;
    } wb_t;

endpackage

//--- ex_issue_reg.sv
`timescale 1ns/1ps

module ex_issue_reg (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  mem_pkg::ex_mem_t     in_entry,
    output logic                 in_ready,
    input  logic                 take,
    output logic                 valid,
    output mem_pkg::ex_mem_t     entry,
    output logic                 req_valid,
    output mem_pkg::muldiv_req_t req
);
    logic accept;

    assign in_ready = ~rst & (~valid | take);
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid     <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            if (accept) begin
                valid <= 1'b1;
            end else if (take) begin
                valid <= 1'b0;
            end
            // an excepting entry never reaches the multiplier or divider
            req_valid <= accept & (in_entry.res_from_mul | in_entry.res_from_div)
                         & ~in_entry.has_exception;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            entry <= in_entry;
        end
    end

    assign req.src1   = entry.src1;
    assign req.src2   = entry.src2;
    assign req.mul_op = entry.mul_op;
    assign req.div_op = entry.div_op;
    assign req.is_div = entry.res_from_div;

endmodule

//--- muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  req_valid,
    input  mem_pkg::muldiv_req_t  req,
    input  logic                  resp_ready,
    output logic                  resp_valid,
    output mem_pkg::muldiv_resp_t resp
);
    import mem_pkg::*;

    logic        busy;
    logic [5:0]  step_cnt;
    logic [31:0] div_rem;
    logic [31:0] div_quo;
    logic [31:0] divisor;
    logic        quo_neg;
    logic        rem_neg;
    logic        div_signed;
    logic        mul_signed;
    logic [31:0] src1_mag;
    logic [31:0] src2_mag;
    logic [63:0] mul_full;

    // one restoring step, returns the new remainder and quotient
    function automatic logic [63:0] div_step(input logic [31:0] rem,
                                             input logic [31:0] quo,
                                             input logic [31:0] dsor);
        logic [32:0] shifted;
        logic [32:0] diff;
        shifted = {rem, quo[31]};
        diff    = shifted - {1'b0, dsor};
        if (diff[32]) begin
            return {shifted[31:0], quo[30:0], 1'b0};
        end
        return {diff[31:0], quo[30:0], 1'b1};
    endfunction

    assign div_signed = req.div_op[div_q_s] | req.div_op[div_r_s];
    assign mul_signed = ~req.mul_op[mul_hi_u];
    assign src1_mag   = (div_signed & req.src1[31]) ? -req.src1 : req.src1;
    assign src2_mag   = (div_signed & req.src2[31]) ? -req.src2 : req.src2;
    assign mul_full   = $signed({mul_signed & req.src1[31], req.src1})
                      * $signed({mul_signed & req.src2[31], req.src2});

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            busy       <= 1'b0;
            step_cnt   <= 6'd0;
            resp_valid <= 1'b0;
        end else begin
            if (resp_valid & resp_ready) begin
                resp_valid <= 1'b0;
            end
            if (req_valid & req.is_div) begin
                busy     <= 1'b1;
                step_cnt <= 6'd1;
            end else if (req_valid) begin
                resp_valid <= 1'b1;
            end else if (busy & (step_cnt == 6'd32)) begin
                busy       <= 1'b0;
                resp_valid <= 1'b1;
            end else if (busy) begin
                step_cnt <= step_cnt + 6'd1;
            end
        end
    end

    // the first step is taken while loading, which gives 32 steps by count 32
    always_ff @(posedge clk) begin
        if (req_valid & req.is_div) begin
            {div_rem, div_quo} <= div_step(32'd0, src1_mag, src2_mag);
            divisor <= src2_mag;
            quo_neg <= div_signed & (req.src1[31] ^ req.src2[31]);
            rem_neg <= div_signed & req.src1[31];
        end else if (req_valid) begin
            resp.product <= mul_full;
        end else if (busy & (step_cnt == 6'd32)) begin
            resp.quotient  <= quo_neg ? -div_quo : div_quo;
            resp.remainder <= rem_neg ? -div_rem : div_rem;
        end else if (busy) begin
            {div_rem, div_quo} <= div_step(div_rem, div_quo, divisor);
        end
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  in_valid,
    input  mem_pkg::ex_mem_t      entry,
    output logic                  take,
    input  logic                  out_ready,
    output logic                  out_valid,
    output mem_pkg::mem_wb_t      out,
    output logic                  resp_ready,
    input  logic                  resp_valid,
    input  mem_pkg::muldiv_resp_t resp,
    output logic                  ram_en,
    output logic [3:0]            ram_we,
    output logic [31:0]           ram_addr,
    output logic [31:0]           ram_wdata
);
    import mem_pkg::*;

    logic        needs_md;
    logic        ready_go;
    logic        advance;
    logic [31:0] sel_result;
    logic [3:0]  lane_mask;

    assign needs_md   = entry.res_from_mul | entry.res_from_div;
    // the response is only consumed in a cycle the stage can advance
    assign resp_ready = in_valid & needs_md & ~entry.has_exception & out_ready;
    assign ready_go   = ~in_valid | flush | entry.has_exception | ~needs_md
                      | (resp_ready & resp_valid);
    assign advance    = in_valid & ready_go & out_ready;

    // a flushed entry is dropped even while writeback is stalled
    assign take = in_valid & (flush | (ready_go & out_ready));

    always_comb begin
        sel_result = entry.result;
        if (entry.res_from_div) begin
            if (entry.div_op[div_q_s] | entry.div_op[div_q_u]) begin
                sel_result = resp.quotient;
            end else if (entry.div_op[div_r_s] | entry.div_op[div_r_u]) begin
                sel_result = resp.remainder;
            end
        end else if (entry.res_from_mul) begin
            if (entry.mul_op[mul_lo]) begin
                sel_result = resp.product[31:0];
            end else if (entry.mul_op[mul_hi_s] | entry.mul_op[mul_hi_u]) begin
                sel_result = resp.product[63:32];
            end
        end
    end

    always_comb begin
        lane_mask = 4'b0000;
        ram_wdata = entry.rkd_value;
        if (entry.mem_op[mem_sb]) begin
            lane_mask = 4'b0001 << entry.result[1:0];
            ram_wdata = {4{entry.rkd_value[7:0]}};
        end else if (entry.mem_op[mem_sh]) begin
            lane_mask = 4'b0011 << {entry.result[1], 1'b0};
            ram_wdata = {2{entry.rkd_value[15:0]}};
        end else if (entry.mem_op[mem_sw]) begin
            lane_mask = 4'b1111;
        end
    end

    assign ram_en   = advance;
    assign ram_we   = {4{advance & ~flush & ~entry.has_exception & entry.mem_we}} & lane_mask;
    assign ram_addr = {entry.result[31:2], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= in_valid & ready_go & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out.pc            <= entry.pc;
            out.result        <= sel_result;
            out.mem_op        <= entry.mem_op;
            out.res_from_mem  <= entry.res_from_mem;
            out.gr_we         <= entry.gr_we;
            out.dest          <= entry.dest;
            out.has_exception <= entry.has_exception;
            out.ecode         <= entry.ecode;
        end
    end

endmodule

//--- data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_addr_bits = 8
) (
    input  logic        clk,
    input  logic        en,
    input  logic [3:0]  we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);
    logic [31:0] mem [0:(1 << ram_addr_bits) - 1] = '{default: '0};
    logic [ram_addr_bits-1:0] word_addr;

    assign word_addr = addr[ram_addr_bits+1:2];

    // read returns the old word when it is written in the same cycle
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rdata <= mem[word_addr];
        end
    end

endmodule

//--- load_writeback.sv
`timescale 1ns/1ps

module load_writeback (
    input  logic             in_valid,
    input  mem_pkg::mem_wb_t in,
    input  logic [31:0]      rdata,
    output logic             wb_valid,
    output mem_pkg::wb_t     wb
);
    import mem_pkg::*;

    logic [31:0] shifted;
    logic [31:0] load_value;

    // move the addressed byte or half-word down to bit 0
    assign shifted = rdata >> {in.result[1:0], 3'b000};

    always_comb begin
        load_value = 32'd0;
        if (in.mem_op[mem_lb]) begin
            load_value = {{24{shifted[7]}}, shifted[7:0]};
        end else if (in.mem_op[mem_lbu]) begin
            load_value = {24'd0, shifted[7:0]};
        end else if (in.mem_op[mem_lh]) begin
            load_value = {{16{shifted[15]}}, shifted[15:0]};
        end else if (in.mem_op[mem_lhu]) begin
            load_value = {16'd0, shifted[15:0]};
        end else if (in.mem_op[mem_lw]) begin
            load_value = rdata;
        end
    end

    assign wb_valid = in_valid;
    assign wb.pc    = in.pc;
    assign wb.dest  = in.dest;
    assign wb.we    = in.gr_we & ~in.has_exception;
    assign wb.data  = in.res_from_mem ? load_value : in.result;
    assign wb.exc   = in.has_exception;
    assign wb.ecode = in.ecode;

endmodule

//--- mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int ram_addr_bits = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  mem_pkg::ex_mem_t in_entry,
    input  logic             flush,
    input  logic             wb_ready,
    output logic             in_ready,
    output logic             wb_valid,
    output mem_pkg::wb_t     wb
);
    import mem_pkg::*;

    logic         issue_valid;
    ex_mem_t      issue_entry;
    logic         take;
    logic         req_valid;
    muldiv_req_t  req;
    logic         resp_ready;
    logic         resp_valid;
    muldiv_resp_t resp;
    logic         stage_valid;
    mem_wb_t      stage_out;
    logic         ram_en;
    logic [3:0]   ram_we;
    logic [31:0]  ram_addr;
    logic [31:0]  ram_wdata;
    logic [31:0]  ram_rdata;

    ex_issue_reg ex_issue_reg_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_entry  (in_entry),
        .in_ready  (in_ready),
        .take      (take),
        .valid     (issue_valid),
        .entry     (issue_entry),
        .req_valid (req_valid),
        .req       (req)
    );

    muldiv_unit muldiv_unit_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .req_valid  (req_valid),
        .req        (req),
        .resp_ready (resp_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    mem_stage mem_stage_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .in_valid   (issue_valid),
        .entry      (issue_entry),
        .take       (take),
        .out_ready  (wb_ready),
        .out_valid  (stage_valid),
        .out        (stage_out),
        .resp_ready (resp_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata)
    );

    data_ram #(
        .ram_addr_bits (ram_addr_bits)
    ) data_ram_i (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    load_writeback load_writeback_i (
        .in_valid (stage_valid),
        .in       (stage_out),
        .rdata    (ram_rdata),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

endmodule

//--- tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_pkg::*;

    localparam string stim_file       = "mem_stim.txt";
    localparam int    cycles_per_line = 60;
    localparam int    div_latency     = 33;

    logic    clk;
    logic    rst;
    logic    in_valid;
    ex_mem_t in_entry;
    logic    flush;
    logic    wb_ready;
    logic    in_ready;
    logic    wb_valid;
    wb_t     wb;

    // one slot per stim line, expected records only for lines that are not flushed
    ex_mem_t entry_q[$];
    bit      flush_q[$];
    wb_t     exp_q[$];
    string   name_q[$];

    wb_t     exp_wb;
    string   exp_name;
    int      seed        = 19659;
    int      cycle_cnt   = 0;
    int      cycle_limit = 0;

    mem_subsys_top #(
        .ram_addr_bits (8)
    ) mem_subsys_top_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_entry (in_entry),
        .flush    (flush),
        .wb_ready (wb_ready),
        .in_ready (in_ready),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic string format_record(input wb_t r);
        return $sformatf("pc=%h dest=%0d we=%b data=%h exc=%b ecode=%h",
                         r.pc, r.dest, r.we, r.data, r.exc, r.ecode);
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          cnt;
        string       line;
        string       name;
        logic [7:0]  mop;
        logic [2:0]  mul;
        logic [3:0]  dv;
        logic        rmul;
        logic        rdiv;
        logic        rmem;
        logic        gwe;
        logic        mwe;
        logic [4:0]  dest;
        logic        exc;
        logic [5:0]  ecode;
        logic        fl;
        logic [31:0] pc;
        logic [31:0] res;
        logic [31:0] rkd;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] expd;
        ex_mem_t     e;
        wb_t         w;
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", stim_file);
            $display("CHECKS FAILED");
            $fatal(1, "no stimulus");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    cnt = $sscanf(line,
                        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, mop, mul, dv, rmul, rdiv, rmem, gwe, mwe, dest, exc,
                        ecode, fl, pc, res, rkd, s1, s2, expd);
                    if (cnt != 19) begin
                        $display("malformed stimulus line: %s", line);
                        $display("CHECKS FAILED");
                        $fatal(1, "bad stimulus file");
                    end else begin
                        e               = '0;
                        e.pc            = pc;
                        e.result        = res;
                        e.rkd_value     = rkd;
                        e.src1          = s1;
                        e.src2          = s2;
                        e.mem_op        = mop;
                        e.mul_op        = mul;
                        e.div_op        = dv;
                        e.res_from_mul  = rmul;
                        e.res_from_div  = rdiv;
                        e.res_from_mem  = rmem;
                        e.gr_we         = gwe;
                        e.mem_we        = mwe;
                        e.dest          = dest;
                        e.has_exception = exc;
                        e.ecode         = ecode;
                        entry_q.push_back(e);
                        flush_q.push_back(fl);
                        // an excepting instruction never writes its register
                        if (!fl) begin
                            w.pc    = pc;
                            w.dest  = dest;
                            w.we    = gwe & ~exc;
                            w.data  = expd;
                            w.exc   = exc;
                            w.ecode = ecode;
                            exp_q.push_back(w);
                            name_q.push_back(name);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // holds the entry until it is accepted, then flushes it in the next cycle if asked
    task automatic drive_entry(input ex_mem_t e, input bit with_flush);
        @(negedge clk);
        in_valid = 1'b1;
        in_entry = e;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        if (with_flush) begin
            @(negedge clk);
            in_valid = 1'b0;
            flush    = 1'b1;
            @(negedge clk);
            flush    = 1'b0;
            // stay idle past the point where an aborted divide would have answered,
            // so a leftover response would be picked up by the next divide
            repeat (div_latency + 1) @(negedge clk);
        end
    endtask

    initial begin
        wb_ready = 1'b0;
        forever begin
            @(negedge clk);
            wb_ready = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_entry = '0;
        flush    = 1'b0;
        load_stimulus();
        cycle_limit = cycles_per_line * entry_q.size();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < entry_q.size(); i++) begin
            drive_entry(entry_q[i], flush_q[i]);
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    always @(posedge clk) begin
        if (!rst && wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                $display("writeback from pc %h arrived with none expected", wb.pc);
                $display("CHECKS FAILED");
                $fatal(1, "unexpected writeback");
            end else begin
                exp_wb   = exp_q.pop_front();
                exp_name = name_q.pop_front();
                assert (wb === exp_wb) else begin
                    $display("mismatch %s expected %s actual %s", exp_name,
                             format_record(exp_wb), format_record(wb));
                    $display("CHECKS FAILED");
                    $fatal(1, "writeback check failed");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

//--- mem_stim.txt
# name mem_op mul_op div_op res_mul res_div res_mem gr_we mem_we dest exc ecode flush
# pc result rkd_value src1 src2 expected_data, all numbers in hex
alu_add     00 0 0 0 0 0 1 0 05 0 00 0 100 12345678 0        0        0        12345678
alu_no_we   00 0 0 0 0 0 0 0 00 0 00 0 104 deadbeef 0        0        0        deadbeef
st_word     80 0 0 0 0 0 0 1 00 0 00 0 108 40       8899aabb 0        0        40
st_byte     20 0 0 0 0 0 0 1 00 0 00 0 10c 41       12345611 0        0        41
st_half     40 0 0 0 0 0 0 1 00 0 00 0 110 42       ffffcdef 0        0        42
ld_word     04 0 0 0 0 1 1 0 06 0 00 0 114 40       0        0        0        cdef11bb
ld_byte_0   01 0 0 0 0 1 1 0 07 0 00 0 118 40       0        0        0        ffffffbb
ld_ubyte_1  08 0 0 0 0 1 1 0 08 0 00 0 11c 41       0        0        0        00000011
ld_byte_2   01 0 0 0 0 1 1 0 09 0 00 0 120 42       0        0        0        ffffffef
ld_ubyte_3  08 0 0 0 0 1 1 0 0a 0 00 0 124 43       0        0        0        000000cd
ld_half_0   02 0 0 0 0 1 1 0 0b 0 00 0 128 40       0        0        0        000011bb
ld_half_2   02 0 0 0 0 1 1 0 0c 0 00 0 12c 42       0        0        0        ffffcdef
ld_uhalf_2  10 0 0 0 0 1 1 0 0d 0 00 0 130 42       0        0        0        0000cdef
mul_lo      00 1 0 1 0 0 1 0 0e 0 00 0 134 0        0        fffffffe 3        fffffffa
mul_hi_s    00 2 0 1 0 0 1 0 0f 0 00 0 138 0        0        fffffffe 3        ffffffff
mul_hi_u    00 4 0 1 0 0 1 0 10 0 00 0 13c 0        0        fffffffe 3        00000002
div_q_s     00 0 1 0 1 0 1 0 11 0 00 0 140 0        0        ffffff9c fffffff9 0000000e
div_q_s_neg 00 0 1 0 1 0 1 0 12 0 00 0 144 0        0        7        fffffffe fffffffd
div_r_s     00 0 4 0 1 0 1 0 13 0 00 0 148 0        0        fffffff9 2        ffffffff
div_q_u     00 0 2 0 1 0 1 0 14 0 00 0 14c 0        0        fffffff9 2        7ffffffc
div_r_u     00 0 8 0 1 0 1 0 15 0 00 0 150 0        0        fffffff9 2        00000001
exc_store   80 0 0 0 0 0 0 1 00 1 0c 0 154 40       01020304 0        0        40
flush_div   00 0 2 0 1 0 1 0 16 0 00 1 158 0        0        1000     10       0
flush_store 80 0 0 0 0 0 0 1 00 0 00 1 15c 40       55667788 0        0        40
ld_after    04 0 0 0 0 1 1 0 17 0 00 0 160 40       0        0        0        cdef11bb
div_after   00 0 2 0 1 0 1 0 18 0 00 0 164 0        0        64       7        0000000e
exc_alu     00 0 0 0 0 0 1 0 19 1 3f 0 168 abcd     0        0        0        abcd

//--- build.f
mem_pkg.sv
ex_issue_reg.sv
muldiv_unit.sv
mem_stage.sv
data_ram.sv
load_writeback.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_mem_subsys --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
